// ==== Bender.yml ====
package:
  name: w_buffer

sources:
  - hw/w_buf_pkg.sv
  - hw/w_fifo.sv
  - hw/w_burst_router.sv
  - hw/w_buffer_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - bench/w_buffer_tb.sv

// ==== include/w_buffer_tb_model.svh ====
`ifndef W_BUFFER_TB_MODEL_SVH
`define W_BUFFER_TB_MODEL_SVH

// Expected decisions in burst order, and beats of accepted bursts only
w_decision_t exp_decisions[$];
w_beat_t     exp_beats[$];

// Linear congruential generator state
int unsigned rng_state = 48;

function automatic int unsigned next_rand();
  rng_state = rng_state * 32'd1103515245 + 32'd12345;
  return (rng_state >> 16) & 32'h0000_ffff;
endfunction

task automatic check_beat(input string name, input w_beat_t exp, input w_beat_t act);
  if (act !== exp) begin
    $display("Error: %s expected %h actual %h", name, exp, act);
    abort_run();
  end
endtask

task automatic check_decision(input string name, input w_decision_t exp,
                              input w_decision_t act);
  if (act !== exp) begin
    $display("Error: %s expected %h actual %h", name, exp, act);
    abort_run();
  end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    $display("Error: %s expected %h actual %h", name, exp, act);
    abort_run();
  end
endtask

`endif

// ==== bench/w_buffer_tb.sv ====
`timescale 1ns/1ps

module w_buffer_tb;

  import w_buf_pkg::*;

  localparam int CLK_PERIOD  = 40;
  localparam int NUM_BURSTS  = 40;
  localparam int MAX_BEATS   = 4;
  localparam int WATCHDOG_NS = NUM_BURSTS * MAX_BEATS * 20 * CLK_PERIOD;

  logic axi4_aclk = 1'b0;
  logic axi4_arstn;
  w_data_t s_axi4_wdata_i;
  w_strb_t s_axi4_wstrb_i;
  w_user_t s_axi4_wuser_i;
  logic s_axi4_wlast_i;
  logic s_axi4_wvalid_i;
  logic s_axi4_wready_o;
  w_data_t m_axi4_wdata_o;
  w_strb_t m_axi4_wstrb_o;
  w_user_t m_axi4_wuser_o;
  logic m_axi4_wlast_o;
  logic m_axi4_wvalid_o;
  logic m_axi4_wready_i;
  logic l1_accept_i;
  logic l1_drop_i;
  logic l1_master_i;
  axi_id_t l1_id_i;
  logic l1_prefetch_i;
  logic l1_hit_i;
  logic l1_done_o;
  logic input_stall_o;
  logic master_select_o;
  logic b_drop_o;
  axi_id_t id_o;
  logic prefetch_o;
  logic hit_o;
  logic b_done_i;

  w_beat_t     burst_beats[NUM_BURSTS][MAX_BEATS];
  int unsigned burst_len[NUM_BURSTS];
  w_decision_t burst_dec[NUM_BURSTS];
  int unsigned dec_count = 0;
  int unsigned bursts_done = 0;
  logic        rst_done = 1'b0;
  logic        w_go = 1'b0;
  logic        drop_wait = 1'b0;

  task automatic abort_run();
    $display("Something failed");
    $fatal(1);
  endtask

`include "w_buffer_tb_model.svh"

  always #(CLK_PERIOD / 2) axi4_aclk = ~axi4_aclk;

  w_buffer_top u_w_buffer_top (.*);

  initial begin
    int unsigned r_hi;
    int unsigned r_lo;
    w_beat_t     beat;
    w_decision_t dec;
    axi4_arstn = 1'b0;
    s_axi4_wdata_i = '0;
    s_axi4_wstrb_i = '0;
    s_axi4_wuser_i = '0;
    s_axi4_wlast_i = 1'b0;
    s_axi4_wvalid_i = 1'b0;
    m_axi4_wready_i = 1'b0;
    l1_accept_i = 1'b0;
    l1_drop_i = 1'b0;
    l1_master_i = 1'b0;
    l1_id_i = '0;
    l1_prefetch_i = 1'b0;
    l1_hit_i = 1'b0;
    b_done_i = 1'b0;
    // Draw all bursts up front and fill the model
    for (int i = 0; i < NUM_BURSTS; i++) begin
      burst_len[i] = 1 + next_rand() % MAX_BEATS;
      dec.action   = (next_rand() % 2 == 0) ? ACT_ACCEPT : ACT_DROP;
      dec.master   = 1'(next_rand() % 2);
      dec.id       = axi_id_t'(next_rand());
      dec.prefetch = 1'(next_rand() % 2);
      dec.hit      = 1'(next_rand() % 2);
      burst_dec[i] = dec;
      exp_decisions.push_back(dec);
      for (int b = 0; b < burst_len[i]; b++) begin
        r_hi = next_rand();
        r_lo = next_rand();
        beat.data = {r_hi[15:0], r_lo[15:0]};
        beat.strb = w_strb_t'(next_rand());
        beat.user = w_user_t'(next_rand());
        beat.last = (b == burst_len[i] - 1);
        burst_beats[i][b] = beat;
        if (dec.action == ACT_ACCEPT) begin
          exp_beats.push_back(beat);
        end
      end
    end
    repeat (3) @(posedge axi4_aclk);
    #1;
    axi4_arstn = 1'b1;
    @(negedge axi4_aclk);
    check_bit("m_axi4_wvalid_o", 1'b0, m_axi4_wvalid_o);
    check_bit("b_drop_o", 1'b0, b_drop_o);
    check_bit("l1_done_o", 1'b0, l1_done_o);
    check_bit("input_stall_o", 1'b0, input_stall_o);
    check_bit("s_axi4_wready_o", 1'b1, s_axi4_wready_o);
    rst_done = 1'b1;
    wait (bursts_done == NUM_BURSTS);
    repeat (4) @(negedge axi4_aclk);
    if (exp_beats.size() != 0 || m_axi4_wvalid_o || b_drop_o) begin
      $display("Activity remained on the W path after all bursts had completed");
      abort_run();
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

  // Request process fills the decision queue first while no beats flow
  initial begin
    logic taken;
    wait (rst_done);
    @(posedge axi4_aclk);
    #1;
    for (int i = 0; i < NUM_BURSTS; i++) begin
      if (i > DECISION_FIFO_DEPTH) begin
        repeat (next_rand() % 3) begin
          @(posedge axi4_aclk);
          #1;
        end
      end
      l1_accept_i   = (burst_dec[i].action == ACT_ACCEPT);
      l1_drop_i     = (burst_dec[i].action == ACT_DROP);
      l1_master_i   = burst_dec[i].master;
      l1_id_i       = burst_dec[i].id;
      l1_prefetch_i = burst_dec[i].prefetch;
      l1_hit_i      = burst_dec[i].hit;
      if (i == DECISION_FIFO_DEPTH) begin
        // Ninth request must wait while the queue is full
        repeat (4) begin
          @(negedge axi4_aclk);
          check_bit("l1_done_o", 1'b0, l1_done_o);
          check_bit("input_stall_o", 1'b1, input_stall_o);
          @(posedge axi4_aclk);
          #1;
        end
        w_go = 1'b1;
      end
      taken = 1'b0;
      while (!taken) begin
        @(negedge axi4_aclk);
        taken = l1_done_o;
        @(posedge axi4_aclk);
        #1;
      end
      l1_accept_i = 1'b0;
      l1_drop_i   = 1'b0;
    end
  end

  // Slave W process with random idle cycles
  initial begin
    logic taken;
    wait (w_go);
    for (int i = 0; i < NUM_BURSTS; i++) begin
      for (int b = 0; b < burst_len[i]; b++) begin
        if (next_rand() % 3 == 0) begin
          @(posedge axi4_aclk);
          #1;
        end
        s_axi4_wdata_i  = burst_beats[i][b].data;
        s_axi4_wstrb_i  = burst_beats[i][b].strb;
        s_axi4_wuser_i  = burst_beats[i][b].user;
        s_axi4_wlast_i  = burst_beats[i][b].last;
        s_axi4_wvalid_i = 1'b1;
        taken = 1'b0;
        while (!taken) begin
          @(negedge axi4_aclk);
          taken = s_axi4_wready_o;
          @(posedge axi4_aclk);
          #1;
        end
        s_axi4_wvalid_i = 1'b0;
      end
    end
  end

  initial begin
    wait (rst_done);
    forever begin
      @(posedge axi4_aclk);
      #1;
      m_axi4_wready_i = (next_rand() % 4 != 0);
    end
  end

  // Response sender answers each drop after a random delay
  initial begin
    wait (rst_done);
    forever begin
      @(posedge axi4_aclk);
      #1;
      b_done_i = 1'b0;
      if (b_drop_o) begin
        repeat (next_rand() % 4) begin
          @(posedge axi4_aclk);
          #1;
        end
        b_done_i = 1'b1;
      end
    end
  end

  always @(negedge axi4_aclk) begin : monitor
    w_beat_t     act_beat;
    w_decision_t head;
    w_decision_t seen;
    logic        room;
    logic        push;
    logic        pop;
    if (rst_done) begin
      room = (dec_count < DECISION_FIFO_DEPTH);
      push = (l1_accept_i | l1_drop_i) & room;
      pop  = 1'b0;
      check_bit("l1_done_o", push, l1_done_o);
      check_bit("input_stall_o", ~room, input_stall_o);
      if (drop_wait) begin
        check_bit("b_drop_o", 1'b1, b_drop_o);
      end
      if (m_axi4_wvalid_o) begin
        if (exp_beats.size() == 0 || exp_decisions[0].action != ACT_ACCEPT) begin
          $display("A master beat appeared while no accepted burst was at the head");
          abort_run();
        end
        head = exp_decisions[0];
        act_beat.data = m_axi4_wdata_o;
        act_beat.strb = m_axi4_wstrb_o;
        act_beat.user = m_axi4_wuser_o;
        act_beat.last = m_axi4_wlast_o;
        check_beat("m_axi4_w beat", exp_beats[0], act_beat);
        check_bit("master_select_o", head.master, master_select_o);
        if (m_axi4_wready_i) begin
          void'(exp_beats.pop_front());
          if (act_beat.last) begin
            void'(exp_decisions.pop_front());
            pop = 1'b1;
          end
        end
      end
      if (b_drop_o) begin
        if (exp_decisions.size() == 0) begin
          $display("An error response was requested with no burst outstanding");
          abort_run();
        end
        seen.action   = ACT_DROP;
        seen.master   = master_select_o;
        seen.id       = id_o;
        seen.prefetch = prefetch_o;
        seen.hit      = hit_o;
        check_decision("drop decision", exp_decisions[0], seen);
        if (b_done_i) begin
          void'(exp_decisions.pop_front());
          pop = 1'b1;
        end
      end
      drop_wait = b_drop_o & ~b_done_i;
      if (pop) begin
        bursts_done = bursts_done + 1;
      end
      dec_count = dec_count + push - pop;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the bursts did not all complete in the allowed time");
    abort_run();
  end

endmodule

// ==== hw/w_buf_pkg.sv ====
package w_buf_pkg;

  // AXI4 W channel widths
  localparam int AXI_DATA_WIDTH = 32;
  localparam int AXI_STRB_WIDTH = AXI_DATA_WIDTH / 8;
  localparam int AXI_USER_WIDTH = 4;
  localparam int AXI_ID_WIDTH   = 4;

  // Buffer depths
  localparam int INPUT_BUFFER_DEPTH  = 4;
  localparam int DECISION_FIFO_DEPTH = 8;

  typedef logic [AXI_DATA_WIDTH-1:0] w_data_t;
  typedef logic [AXI_STRB_WIDTH-1:0] w_strb_t;
  typedef logic [AXI_USER_WIDTH-1:0] w_user_t;
  typedef logic [AXI_ID_WIDTH-1:0]   axi_id_t;

  // One W beat as stored in the input buffer
  typedef struct packed {
    w_data_t data;
    w_strb_t strb;
    w_user_t user;
    logic    last;
  } w_beat_t;

  localparam int BEAT_WIDTH = $bits(w_beat_t);

  // Translation result for one burst
  typedef enum logic {
    ACT_ACCEPT = 1'b0,
    ACT_DROP   = 1'b1
  } tlb_action_e;

  // One queued decision, in burst order
  typedef struct packed {
    tlb_action_e action;
    logic        master;
    axi_id_t     id;
    logic        prefetch;
    logic        hit;
  } w_decision_t;

  localparam int DECISION_WIDTH = $bits(w_decision_t);

  // Router states
  typedef enum logic {
    RS_ROUTE  = 1'b0,
    RS_B_DROP = 1'b1
  } route_state_e;

endpackage

// ==== hw/w_buffer_top.sv ====
`timescale 1ns/1ps

module w_buffer_top (
  input  logic               axi4_aclk,
  input  logic               axi4_arstn,
  // Slave W port
  input  w_buf_pkg::w_data_t s_axi4_wdata_i,
  input  w_buf_pkg::w_strb_t s_axi4_wstrb_i,
  input  w_buf_pkg::w_user_t s_axi4_wuser_i,
  input  logic               s_axi4_wlast_i,
  input  logic               s_axi4_wvalid_i,
  output logic               s_axi4_wready_o,
  // Master W port
  output w_buf_pkg::w_data_t m_axi4_wdata_o,
  output w_buf_pkg::w_strb_t m_axi4_wstrb_o,
  output w_buf_pkg::w_user_t m_axi4_wuser_o,
  output logic               m_axi4_wlast_o,
  output logic               m_axi4_wvalid_o,
  input  logic               m_axi4_wready_i,
  // Requests from the translation unit
  input  logic               l1_accept_i,
  input  logic               l1_drop_i,
  input  logic               l1_master_i,
  input  w_buf_pkg::axi_id_t l1_id_i,
  input  logic               l1_prefetch_i,
  input  logic               l1_hit_i,
  output logic               l1_done_o,
  output logic               input_stall_o,
  output logic               master_select_o,
  // Response sender
  output logic               b_drop_o,
  output w_buf_pkg::axi_id_t id_o,
  output logic               prefetch_o,
  output logic               hit_o,
  input  logic               b_done_i
);

  import w_buf_pkg::*;

  w_beat_t     s_beat;
  w_beat_t     buf_beat;
  logic        buf_valid;
  logic        buf_ready;

  w_decision_t req_decision;
  w_decision_t head_decision;
  logic        l1_req;
  logic        dec_push;
  logic        dec_room;
  logic        dec_valid;
  logic        dec_ready;

  assign s_beat.data = s_axi4_wdata_i;
  assign s_beat.strb = s_axi4_wstrb_i;
  assign s_beat.user = s_axi4_wuser_i;
  assign s_beat.last = s_axi4_wlast_i;

  // Only accept and drop are possible, so one flag picks the opcode
  assign req_decision.action   = l1_accept_i ? ACT_ACCEPT : ACT_DROP;
  assign req_decision.master   = l1_master_i;
  assign req_decision.id       = l1_id_i;
  assign req_decision.prefetch = l1_prefetch_i;
  assign req_decision.hit      = l1_hit_i;

  assign l1_req        = l1_accept_i | l1_drop_i;
  assign dec_push      = l1_req & dec_room;
  assign l1_done_o     = dec_push;
  assign input_stall_o = ~dec_room;

  w_fifo #(
    .DATA_WIDTH (BEAT_WIDTH),
    .DEPTH      (INPUT_BUFFER_DEPTH)
  ) u_input_buf (
    .axi4_aclk  (axi4_aclk),
    .axi4_arstn (axi4_arstn),
    .data_i     (s_beat),
    .valid_i    (s_axi4_wvalid_i),
    .ready_o    (s_axi4_wready_o),
    .data_o     (buf_beat),
    .valid_o    (buf_valid),
    .ready_i    (buf_ready)
  );

  w_fifo #(
    .DATA_WIDTH (DECISION_WIDTH),
    .DEPTH      (DECISION_FIFO_DEPTH)
  ) u_decision_fifo (
    .axi4_aclk  (axi4_aclk),
    .axi4_arstn (axi4_arstn),
    .data_i     (req_decision),
    .valid_i    (dec_push),
    .ready_o    (dec_room),
    .data_o     (head_decision),
    .valid_o    (dec_valid),
    .ready_i    (dec_ready)
  );

  w_burst_router u_burst_router (
    .axi4_aclk        (axi4_aclk),
    .axi4_arstn       (axi4_arstn),
    .beat_i           (buf_beat),
    .beat_valid_i     (buf_valid),
    .beat_ready_o     (buf_ready),
    .decision_i       (head_decision),
    .decision_valid_i (dec_valid),
    .decision_ready_o (dec_ready),
    .m_axi4_wdata_o   (m_axi4_wdata_o),
    .m_axi4_wstrb_o   (m_axi4_wstrb_o),
    .m_axi4_wuser_o   (m_axi4_wuser_o),
    .m_axi4_wlast_o   (m_axi4_wlast_o),
    .m_axi4_wvalid_o  (m_axi4_wvalid_o),
    .m_axi4_wready_i  (m_axi4_wready_i),
    .master_select_o  (master_select_o),
    .b_drop_o         (b_drop_o),
    .id_o             (id_o),
    .prefetch_o       (prefetch_o),
    .hit_o            (hit_o),
    .b_done_i         (b_done_i)
  );

endmodule

// ==== hw/w_burst_router.sv ====
`timescale 1ns/1ps

module w_burst_router (
  input  logic                  axi4_aclk,
  input  logic                  axi4_arstn,
  // Beats from the input buffer
  input  w_buf_pkg::w_beat_t    beat_i,
  input  logic                  beat_valid_i,
  output logic                  beat_ready_o,
  // Head of the decision queue
  input  w_buf_pkg::w_decision_t decision_i,
  input  logic                  decision_valid_i,
  output logic                  decision_ready_o,
  // Master W port
  output w_buf_pkg::w_data_t    m_axi4_wdata_o,
  output w_buf_pkg::w_strb_t    m_axi4_wstrb_o,
  output w_buf_pkg::w_user_t    m_axi4_wuser_o,
  output logic                  m_axi4_wlast_o,
  output logic                  m_axi4_wvalid_o,
  input  logic                  m_axi4_wready_i,
  output logic                  master_select_o,
  // Response sender handshake
  output logic                  b_drop_o,
  output w_buf_pkg::axi_id_t    id_o,
  output logic                  prefetch_o,
  output logic                  hit_o,
  input  logic                  b_done_i
);

  import w_buf_pkg::*;

  route_state_e state_q;
  route_state_e state_d;
  logic         last_valid;

  // Head decision is visible to the response sender at all times
  assign master_select_o = decision_i.master;
  assign id_o            = decision_i.id;
  assign prefetch_o      = decision_i.prefetch;
  assign hit_o           = decision_i.hit;

  assign b_drop_o   = (state_q == RS_B_DROP);
  assign last_valid = beat_valid_i & beat_i.last;

  always_comb begin
    state_d          = state_q;
    beat_ready_o     = 1'b0;
    decision_ready_o = 1'b0;
    m_axi4_wdata_o   = '0;
    m_axi4_wstrb_o   = '0;
    m_axi4_wuser_o   = '0;
    m_axi4_wlast_o   = 1'b0;
    m_axi4_wvalid_o  = 1'b0;

    case (state_q)
      RS_ROUTE: begin
        // Without a decision no beat may move
        if (decision_valid_i) begin
          if (decision_i.action == ACT_ACCEPT) begin
            m_axi4_wdata_o   = beat_i.data;
            m_axi4_wstrb_o   = beat_i.strb;
            m_axi4_wuser_o   = beat_i.user;
            m_axi4_wlast_o   = beat_i.last;
            m_axi4_wvalid_o  = beat_valid_i;
            beat_ready_o     = m_axi4_wready_i;
            // Release the decision with the last forwarded beat
            decision_ready_o = last_valid & m_axi4_wready_i;
          end else begin
            // Swallow the burst, then ask for an error response
            beat_ready_o = 1'b1;
            if (last_valid) begin
              state_d = RS_B_DROP;
            end
          end
        end
      end

      RS_B_DROP: begin
        decision_ready_o = b_done_i;
        if (b_done_i) begin
          state_d = RS_ROUTE;
        end
      end

      default: begin
        state_d = RS_ROUTE;
      end
    endcase
  end

  always_ff @(posedge axi4_aclk or negedge axi4_arstn) begin
    if (!axi4_arstn) begin
      state_q <= RS_ROUTE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// ==== hw/w_fifo.sv ====
`timescale 1ns/1ps

module w_fifo #(
  parameter int DATA_WIDTH = 8,
  parameter int DEPTH      = 4
) (
  input  logic                  axi4_aclk,
  input  logic                  axi4_arstn,
  // Push side
  input  logic [DATA_WIDTH-1:0] data_i,
  input  logic                  valid_i,
  output logic                  ready_o,
  // Pop side
  output logic [DATA_WIDTH-1:0] data_o,
  output logic                  valid_o,
  input  logic                  ready_i
);

  localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_WIDTH = $clog2(DEPTH + 1);
  localparam logic [PTR_WIDTH-1:0] LAST_IDX = PTR_WIDTH'(DEPTH - 1);
  localparam logic [CNT_WIDTH-1:0] FULL_CNT = CNT_WIDTH'(DEPTH);

  logic [DATA_WIDTH-1:0] mem [DEPTH];
  logic [PTR_WIDTH-1:0]  wr_ptr_q;
  logic [PTR_WIDTH-1:0]  rd_ptr_q;
  logic [CNT_WIDTH-1:0]  count_q;
  logic                  push;
  logic                  pop;

  // Ready follows the full state only and ignores a pop in the same cycle
  assign ready_o = (count_q != FULL_CNT);
  assign valid_o = (count_q != '0);
  assign data_o  = mem[rd_ptr_q];

  assign push = valid_i & ready_o;
  assign pop  = valid_o & ready_i;

  always_ff @(posedge axi4_aclk) begin
    if (push) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge axi4_aclk or negedge axi4_arstn) begin
    if (!axi4_arstn) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == LAST_IDX) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == LAST_IDX) ? '0 : rd_ptr_q + 1'b1;
      end
      // Occupancy only moves when exactly one side transfers
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// ==== w_buffer.f ====
+incdir+include
hw/w_buf_pkg.sv
hw/w_fifo.sv
hw/w_burst_router.sv
hw/w_buffer_top.sv
bench/w_buffer_tb.sv
